// ==== wisc_cpu.f ====
+incdir+source
source/wisc_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/hazard_forward_unit.sv
source/memory_stage.sv
source/wisc_cpu.sv
bench/clock_gen.sv
bench/wisc_cpu_assert.sv
bench/wisc_cpu_tb.sv

// ==== Bender.yml ====
package:
  name: wisc_cpu

sources:
  - include_dirs:
      - source
    files:
      - source/wisc_pkg.sv
      - source/fetch_stage.sv
      - source/decode_stage.sv
      - source/execute_stage.sv
      - source/hazard_forward_unit.sv
      - source/memory_stage.sv
      - source/wisc_cpu.sv
  - target: simulation
    files:
      - bench/clock_gen.sv
      - bench/wisc_cpu_assert.sv
      - bench/wisc_cpu_tb.sv

// ==== bench/wisc_tests.txt ====
// Per test: word count, program words, retire count, retire pairs (reg value), halt PC
// All values hex, the first word is the number of tests
4
// Test 0: ALU ops, byte insert, forwarding, r0 as source and destination
0E
0100 0200 A134 B112 A2FF B2FF 0312 1412
2534 0011 0601 1760 0877 F000
0C
1 0000  2 0000  1 0034  1 1234  2 00FF  2 FFFF
3 1233  4 1235  5 0006  6 1234  7 1234  8 2468
001A
// Test 1: stores, loads, load-use stalls, load into r0
13
0100 A110 0200 A2CD B2AB 9213 8313 0433
9400 8500 9314 8614 1765 8013 0801 8900
9915 8A15 F000
0D
1 0000  1 0010  2 0000  2 00CD  2 ABCD  3 ABCD  4 579A
5 579A  6 ABCD  7 5433  8 0010  9 579A  A 579A
0024
// Test 2: all eight branch conditions, taken and not taken, backward branch
3E
0100 0200 0900 A101 A202 1312 C002 A911
A912 C202 A913 A914 C402 A915 A916 C602
A917 A918 C802 A919 A91A CA02 A91B A91C
CC02 A91D A91E 2411 C202 A921 A922 C002
A923 A924 C802 A925 A926 0500 A5FF B57F
1651 C402 A927 A928 C602 A929 A92A CA02
A92B A92C 0751 CC02 A92D A92E CE03 A92F
A930 F000 A931 CFFD A932 A933
1B
1 0000  2 0000  9 0000  1 0001  2 0002  3 FFFF
9 0013  9 0014  9 0015  9 0016  9 0019  9 001A  9 001D  9 001E
4 0000  9 0023  9 0024
5 0000  5 00FF  5 7FFF  6 7FFE  9 0029  9 002A  9 002B  9 002C
7 8000  9 0031
0072
// Test 3: HLT in a branch shadow, load from cleared memory, halt after a stall
07
0100 CE01 F000 A1AA 8211 0321 F000
04
1 0000  1 00AA  2 0000  3 00AA
000C

// ==== bench/wisc_cpu_tb.sv ====
/*
 * Testbench for the WISC pipelined core
 * Runs the programs of the test file and checks retires, halt and the final PC
 */
`timescale 1ns/1ps
`default_nettype none

module wisc_cpu_tb import wisc_pkg::*; ();

    localparam int TV_WORDS     = 1024;
    localparam int IMEM_WORDS   = 256;
    localparam int RESET_CYCLES = 4;
    // Cycles watched after hlt rises
    localparam int DRAIN_CYCLES = 6;

    logic     clk;
    logic     rst_n;
    word_t    imem_data;
    word_t    imem_addr;
    word_t    pc;
    logic     hlt;
    logic     wb_valid;
    reg_idx_t wb_reg;
    word_t    wb_data;

    // Raw test file and instruction memory model
    word_t tv   [0:TV_WORDS-1];
    word_t imem [0:IMEM_WORDS-1];
    word_t exp_reg_q[$];
    word_t exp_data_q[$];

    int errors;
    int tv_pos;
    int num_tests;
    int limit_cycles;

    clock_gen clock_i (
        .clk (clk)
    );

    wisc_cpu dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_data (imem_data),
        .imem_addr (imem_addr),
        .pc        (pc),
        .hlt       (hlt),
        .wb_valid  (wb_valid),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data)
    );

    // Instruction word at the current PC
    always @(negedge clk) begin
        imem_data = imem[imem_addr[8:1]];
    end

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic word_t take_word();
        word_t w;
        w = tv[tv_pos];
        tv_pos++;
        return w;
    endfunction

    // Program word count over all tests
    function automatic int total_words();
        int pos;
        int words;
        int n;
        int m;
        pos   = 1;
        words = 0;
        for (int t = 0; t < num_tests; t++) begin
            n     = tv[pos];
            words += n;
            pos   += n + 1;
            m     = tv[pos];
            pos   += 2 * m + 2;
        end
        return words;
    endfunction

    // ----------------------------------------
    // Test loading and reset
    // ----------------------------------------
    task automatic load_test(output word_t halt_pc);
        int n;
        int m;
        n = take_word();
        // Stray HLT words tagged with their index
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = 16'hF000 | 16'(i);
        end
        for (int i = 0; i < n; i++) begin
            imem[i] = take_word();
        end
        m = take_word();
        for (int i = 0; i < m; i++) begin
            exp_reg_q.push_back(take_word());
            exp_data_q.push_back(take_word());
        end
        halt_pc = take_word();
    endtask

    task automatic apply_reset(output word_t halt_pc);
        @(negedge clk);
        rst_n = 1'b0;
        exp_reg_q.delete();
        exp_data_q.delete();
        load_test(halt_pc);
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // ----------------------------------------
    // One program, retire order and halt
    // ----------------------------------------
    task automatic run_test(input int test_num);
        word_t halt_pc;
        logic  halted;
        int    drain;
        apply_reset(halt_pc);
        halted = 1'b0;
        drain  = 0;
        while (drain < DRAIN_CYCLES) begin
            @(negedge clk);
            if (wb_valid) begin
                if (halted) begin
                    errors++;
                    $display("Test %0d: r%0d written after halt", test_num, wb_reg);
                end else if (exp_reg_q.size() == 0) begin
                    errors++;
                    $display("Test %0d: unexpected write of %h to r%0d",
                             test_num, wb_data, wb_reg);
                end else begin
                    check_value("wb_reg", {12'h000, wb_reg}, exp_reg_q.pop_front());
                    check_value("wb_data", wb_data, exp_data_q.pop_front());
                end
            end
            // PC parked on the HLT from the first hlt cycle on
            if (halted) begin
                check_value("hlt", {15'h0000, hlt}, 16'h0001);
                check_value("pc", pc, halt_pc);
                check_value("imem_addr", imem_addr, halt_pc);
                drain++;
            end else if (hlt) begin
                halted = 1'b1;
                check_value("pc", pc, halt_pc);
                check_value("imem_addr", imem_addr, halt_pc);
            end
        end
        if (exp_reg_q.size() != 0) begin
            errors++;
            $display("Test %0d: %0d expected register writes missing at halt",
                     test_num, exp_reg_q.size());
        end
    endtask

    initial begin
        errors       = 0;
        tv_pos       = 0;
        num_tests    = 0;
        limit_cycles = 0;
        rst_n        = 1'b0;
        imem_data    = '0;
        $readmemh("bench/wisc_tests.txt", tv);
        if ($isunknown(tv[0]) || (tv[0] == '0)) begin
            errors++;
            $display("Test file bench/wisc_tests.txt is missing or holds no tests");
        end else begin
            num_tests    = tv[0];
            tv_pos       = 1;
            limit_cycles = 40 * total_words() + 100;
        end
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("Summary: %0d tests run, %0d errors", num_tests, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog allows 40 cycles per program word plus 100
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        errors++;
        $display("Timeout: the programs did not finish within %0d cycles", limit_cycles);
        $display("Summary: %0d tests run, %0d errors", num_tests, errors);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/wisc_cpu_assert.sv ====
/*
 * Bound checks on the WISC core
 * Sticky halt, no retire of r0, redirect and stall effect on the PC
 */
`timescale 1ns/1ps
`default_nettype none

module wisc_cpu_assert import wisc_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     hlt,
    input logic     wb_valid,
    input reg_idx_t wb_reg,
    input logic     stall,
    input logic     redirect,
    input word_t    redirect_pc,
    input word_t    pc
);

    // Halt stays up until reset
    hlt_sticky: assert property (@(posedge clk) disable iff (!rst_n) hlt |=> hlt)
        else $error("hlt fell without reset");

    // r0 is never a retire target
    retire_not_r0: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> (wb_reg != '0))
        else $error("retire reported for r0");

    // Taken branch wins over stall and over a fetched HLT
    redirect_wins: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |=> (pc == $past(redirect_pc)))
        else $error("fetch did not follow the branch target");

    // Load-use bubble holds the fetch address
    stall_holds_pc: assert property (@(posedge clk) disable iff (!rst_n)
        (stall && !redirect) |=> $stable(pc))
        else $error("PC moved during a stall");

endmodule

bind wisc_cpu wisc_cpu_assert assert_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .hlt         (hlt),
    .wb_valid    (wb_valid),
    .wb_reg      (wb_reg),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .pc          (pc)
);

`default_nettype wire

// ==== bench/clock_gen.sv ====
/*
 * Testbench clock source, 8 ns period
 */
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic clk
);

    // Half period of 4 ns
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== source/wisc_cpu.sv ====
/*
 * WISC five-stage pipelined core
 * IF, ID, EX, MEM, WB with forwarding, load-use stall, branch flush and halt
 */
`timescale 1ns/1ps
`default_nettype none

module wisc_cpu import wisc_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  word_t    imem_data,
    output word_t    imem_addr,
    output word_t    pc,
    output logic     hlt,
    output logic     wb_valid,
    output reg_idx_t wb_reg,
    output word_t    wb_data
);

    // Stage-to-stage pipeline registers
    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;

    // Hazard and redirect controls
    logic     stall;
    logic     redirect;
    word_t    redirect_pc;
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;
    fwd_sel_t fwd_store;

    // Sticky halt once the first HLT retires
    logic halt_q;
    logic halt_now;

    // ----------------------------------------
    // Stages
    // ----------------------------------------
    fetch_stage fetch_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_data   (imem_data),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_addr   (imem_addr),
        .if_id       (if_id)
    );

    // Taken branch in EX kills the instruction now in ID
    decode_stage decode_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .if_id  (if_id),
        .stall  (stall),
        .flush  (redirect),
        .mem_wb (mem_wb),
        .id_ex  (id_ex)
    );

    execute_stage execute_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .id_ex       (id_ex),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .fwd_store   (fwd_store),
        .ex_mem      (ex_mem),
        .mem_wb      (mem_wb),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    memory_stage memory_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .ex_mem (ex_mem),
        .mem_wb (mem_wb)
    );

    hazard_forward_unit hazard_i (
        .if_id     (if_id),
        .id_ex     (id_ex),
        .ex_mem    (ex_mem),
        .mem_wb    (mem_wb),
        .stall     (stall),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b),
        .fwd_store (fwd_store)
    );

    // ----------------------------------------
    // Halt and retire port
    // ----------------------------------------
    assign halt_now = mem_wb.valid & mem_wb.is_halt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            halt_q <= 1'b0;
        end else if (halt_now) begin
            halt_q <= 1'b1;
        end
    end

    // Rises in the HLT's WB cycle, held afterwards
    assign hlt = halt_q | halt_now;

    // r0 writes never carry write_reg, so never retire
    assign wb_valid = mem_wb.valid & mem_wb.write_reg;
    assign wb_reg   = mem_wb.rd;
    assign wb_data  = mem_wb.result;

    // Architectural PC is the fetch address
    assign pc = imem_addr;

endmodule

`default_nettype wire

// ==== source/memory_stage.sv ====
/*
 * Memory stage
 * Word-addressed data memory and the MEM/WB register
 */
`timescale 1ns/1ps
`default_nettype none

`include "wisc_defs.svh"

module memory_stage import wisc_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  ex_mem_t ex_mem,
    output mem_wb_t mem_wb
);

    localparam int DMEM_AW = $clog2(`DMEM_WORDS);

    word_t              dmem [0:`DMEM_WORDS-1];
    logic [DMEM_AW-1:0] dmem_addr;
    word_t              load_data;

    // Byte address to word index
    assign dmem_addr = ex_mem.result[DMEM_AW:1];
    assign load_data = dmem[dmem_addr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_mem.valid && ex_mem.mem_write) begin
            dmem[dmem_addr] <= ex_mem.store_data;
        end
    end

    // MEM/WB, load data replaces the address
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_wb.valid <= 1'b0;
        end else begin
            mem_wb.valid     <= ex_mem.valid;
            mem_wb.rd        <= ex_mem.rd;
            mem_wb.result    <= ex_mem.mem_read ? load_data : ex_mem.result;
            mem_wb.write_reg <= ex_mem.write_reg;
            mem_wb.is_halt   <= ex_mem.is_halt;
        end
    end

endmodule

`default_nettype wire

// ==== source/hazard_forward_unit.sv ====
/*
 * Hazard and forwarding unit
 * Load-use stall from IF/ID against ID/EX, operand selects for EX
 */
`timescale 1ns/1ps
`default_nettype none

module hazard_forward_unit import wisc_pkg::*; (
    input  if_id_t   if_id,
    input  id_ex_t   id_ex,
    input  ex_mem_t  ex_mem,
    input  mem_wb_t  mem_wb,
    output logic     stall,
    output fwd_sel_t fwd_a,
    output fwd_sel_t fwd_b,
    output fwd_sel_t fwd_store
);

    opcode_t  op;
    logic     is_byte;
    logic     reads_a;
    logic     reads_b;
    reg_idx_t src_a;
    reg_idx_t src_b;
    logic     load_in_ex;

    // Youngest writer wins, EX/MEM before MEM/WB
    function automatic fwd_sel_t pick(input reg_idx_t idx);
        if (ex_mem.valid && ex_mem.write_reg && (ex_mem.rd != '0) && (ex_mem.rd == idx)) begin
            return FWD_EXMEM;
        end else if (mem_wb.valid && mem_wb.write_reg && (mem_wb.rd != '0) &&
                     (mem_wb.rd == idx)) begin
            return FWD_MEMWB;
        end
        return FWD_NONE;
    endfunction

    // ----------------------------------------
    // Sources read by the instruction in ID
    // ----------------------------------------
    assign op      = opcode_t'(if_id.instr[15:12]);
    assign is_byte = (op == OP_LLB) || (op == OP_HLB);
    assign reads_a = (op == OP_ADD) || (op == OP_SUB) || (op == OP_XOR) ||
                     (op == OP_LW) || (op == OP_SW) || is_byte;
    assign reads_b = (op == OP_ADD) || (op == OP_SUB) || (op == OP_XOR) || (op == OP_SW);
    assign src_a   = is_byte ? if_id.instr[11:8] : if_id.instr[7:4];
    assign src_b   = (op == OP_SW) ? if_id.instr[11:8] : if_id.instr[3:0];

    // Load data exists only after MEM, one bubble needed
    assign load_in_ex = id_ex.valid && id_ex.mem_read && id_ex.write_reg;
    assign stall = if_id.valid && load_in_ex &&
                   ((reads_a && (src_a == id_ex.rd)) || (reads_b && (src_b == id_ex.rd)));

    // Store data and ALU operand B share the second read port
    assign fwd_a     = pick(id_ex.rs);
    assign fwd_b     = id_ex.mem_write ? FWD_NONE : pick(id_ex.rt);
    assign fwd_store = id_ex.mem_write ? pick(id_ex.rt) : FWD_NONE;

endmodule

`default_nettype wire

// ==== source/execute_stage.sv ====
/*
 * Execute stage
 * Operand forwarding, ALU, flag register, branch resolution, EX/MEM register
 */
`timescale 1ns/1ps
`default_nettype none

`include "wisc_defs.svh"

module execute_stage import wisc_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  id_ex_t   id_ex,
    input  fwd_sel_t fwd_a,
    input  fwd_sel_t fwd_b,
    input  fwd_sel_t fwd_store,
    output ex_mem_t  ex_mem,
    input  mem_wb_t  mem_wb,
    output logic     redirect,
    output word_t    redirect_pc
);

    word_t  op_a;
    word_t  op_b;
    word_t  store_val;
    word_t  sum;
    word_t  diff;
    word_t  alu_res;
    logic   ovf;
    flags_t flags_q;
    flags_t flags_d;

    function automatic word_t operand(input fwd_sel_t sel, input word_t reg_val);
        case (sel)
            FWD_EXMEM: return ex_mem.result;
            FWD_MEMWB: return mem_wb.result;
            default:   return reg_val;
        endcase
    endfunction

    function automatic logic cond_met(input cond_t c, input flags_t f);
        case (c)
            `COND_NE: return !f[`FLAG_Z];
            `COND_EQ: return f[`FLAG_Z];
            `COND_GT: return !f[`FLAG_Z] && !f[`FLAG_N];
            `COND_LT: return f[`FLAG_N];
            `COND_GE: return f[`FLAG_Z] || !f[`FLAG_N];
            `COND_LE: return f[`FLAG_N] || f[`FLAG_Z];
            `COND_OV: return f[`FLAG_V];
            default:  return 1'b1;
        endcase
    endfunction

    assign op_a      = operand(fwd_a, id_ex.rs_data);
    assign op_b      = operand(fwd_b, id_ex.rt_data);
    assign store_val = operand(fwd_store, id_ex.rt_data);

    // ----------------------------------------
    // ALU
    // ----------------------------------------
    assign sum  = op_a + op_b;
    assign diff = op_a - op_b;
    assign ovf  = (id_ex.opcode == OP_SUB) ?
                  ((op_a[15] != op_b[15]) && (diff[15] != op_a[15])) :
                  ((op_a[15] == op_b[15]) && (sum[15] != op_a[15]));

    always_comb begin
        case (id_ex.opcode)
            OP_ADD:       alu_res = sum;
            OP_SUB:       alu_res = diff;
            OP_XOR:       alu_res = op_a ^ op_b;
            OP_LLB:       alu_res = {op_a[15:8], id_ex.imm[7:0]};
            OP_HLB:       alu_res = {id_ex.imm[7:0], op_a[7:0]};
            // Word-aligned base plus scaled offset
            OP_LW, OP_SW: alu_res = {op_a[15:1], 1'b0} + id_ex.imm;
            default:      alu_res = '0;
        endcase
    end

    // XOR touches Z only
    always_comb begin
        flags_d = flags_q;
        flags_d[`FLAG_Z] = (alu_res == '0);
        if (id_ex.opcode != OP_XOR) begin
            flags_d[`FLAG_V] = ovf;
            flags_d[`FLAG_N] = alu_res[15];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flags_q <= '0;
        end else if (id_ex.valid && id_ex.sets_flags) begin
            flags_q <= flags_d;
        end
    end

    // ----------------------------------------
    // Branch and EX/MEM
    // ----------------------------------------
    assign redirect    = id_ex.valid && id_ex.is_branch && cond_met(id_ex.cond, flags_q);
    assign redirect_pc = id_ex.pc_next + id_ex.imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem.valid <= 1'b0;
        end else begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.result     <= alu_res;
            ex_mem.store_data <= store_val;
            ex_mem.write_reg  <= id_ex.write_reg;
            ex_mem.mem_read   <= id_ex.mem_read;
            ex_mem.mem_write  <= id_ex.mem_write;
            ex_mem.is_halt    <= id_ex.is_halt;
        end
    end

endmodule

`default_nettype wire

// ==== source/decode_stage.sv ====
/*
 * Decode stage
 * Control decode, register file with write-through, immediates, ID/EX register
 */
`timescale 1ns/1ps
`default_nettype none

module decode_stage import wisc_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  if_id_t  if_id,
    input  logic    stall,
    input  logic    flush,
    input  mem_wb_t mem_wb,
    output id_ex_t  id_ex
);

    opcode_t  op;
    reg_idx_t rd_f;
    reg_idx_t rs_f;
    reg_idx_t rt_f;
    reg_idx_t src_a;
    reg_idx_t src_b;
    word_t    imm;
    logic     is_alu;
    logic     is_byte;
    logic     writes;
    id_ex_t   id_ex_d;

    // r1..r15, entry 0 is never written
    word_t regs [0:15];

    // ----------------------------------------
    // Field split and control
    // ----------------------------------------
    assign op   = opcode_t'(if_id.instr[15:12]);
    assign rd_f = if_id.instr[11:8];
    assign rs_f = if_id.instr[7:4];
    assign rt_f = if_id.instr[3:0];

    assign is_alu  = (op == OP_ADD) || (op == OP_SUB) || (op == OP_XOR);
    assign is_byte = (op == OP_LLB) || (op == OP_HLB);
    assign writes  = is_alu || is_byte || (op == OP_LW);

    // LLB/HLB modify rd in place
    assign src_a = is_byte ? rd_f : rs_f;
    // SW stores the value of rd
    assign src_b = (op == OP_SW) ? rd_f : rt_f;

    // Memory offset is 4 bits unsigned, branch offset signed 9 bits
    always_comb begin
        case (op)
            OP_LW, OP_SW:   imm = {11'b0, rt_f, 1'b0};
            OP_LLB, OP_HLB: imm = {8'b0, if_id.instr[7:0]};
            OP_B:           imm = {{6{if_id.instr[8]}}, if_id.instr[8:0], 1'b0};
            default:        imm = '0;
        endcase
    end

    // ----------------------------------------
    // Register file
    // ----------------------------------------
    // Same-cycle WB write is visible to the read
    function automatic word_t read_port(input reg_idx_t idx);
        word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (mem_wb.valid && mem_wb.write_reg && (mem_wb.rd == idx)) begin
            val = mem_wb.result;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (mem_wb.valid && mem_wb.write_reg) begin
            regs[mem_wb.rd] <= mem_wb.result;
        end
    end

    // ----------------------------------------
    // ID/EX
    // ----------------------------------------
    always_comb begin
        id_ex_d.valid      = if_id.valid;
        id_ex_d.opcode     = op;
        id_ex_d.rs         = src_a;
        id_ex_d.rt         = src_b;
        id_ex_d.rd         = rd_f;
        id_ex_d.rs_data    = read_port(src_a);
        id_ex_d.rt_data    = read_port(src_b);
        id_ex_d.imm        = imm;
        id_ex_d.pc_next    = if_id.pc_next;
        id_ex_d.cond       = if_id.instr[11:9];
        // Writes to r0 dropped here
        id_ex_d.write_reg  = writes && (rd_f != '0);
        id_ex_d.mem_read   = (op == OP_LW);
        id_ex_d.mem_write  = (op == OP_SW);
        id_ex_d.sets_flags = is_alu;
        id_ex_d.is_branch  = (op == OP_B);
        id_ex_d.is_halt    = (op == OP_HLT);
    end

    // Bubble on load-use stall or branch flush
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex <= id_ex_d;
            if (stall || flush) begin
                id_ex.valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/fetch_stage.sv ====
/*
 * Fetch stage
 * PC register, next-PC priority and the IF/ID register
 */
`timescale 1ns/1ps
`default_nettype none

`include "wisc_defs.svh"

module fetch_stage import wisc_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  word_t  imem_data,
    input  logic   stall,
    input  logic   redirect,
    input  word_t  redirect_pc,
    output word_t  imem_addr,
    output if_id_t if_id
);

    word_t pc_q;
    word_t pc_plus2;
    logic  fetch_hlt;

    assign imem_addr = pc_q;
    assign pc_plus2  = pc_q + 16'd2;

    // HLT seen at fetch parks the PC on itself
    assign fetch_hlt = (opcode_t'(imem_data[15:12]) == OP_HLT);

    // Redirect beats stall, stall beats a new fetch
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q        <= `RESET_PC;
            if_id.valid <= 1'b0;
        end else if (redirect) begin
            pc_q        <= redirect_pc;
            if_id.valid <= 1'b0;
        end else if (!stall) begin
            if (!fetch_hlt) begin
                pc_q <= pc_plus2;
            end
            if_id.valid   <= 1'b1;
            if_id.instr   <= imem_data;
            if_id.pc_next <= pc_plus2;
        end
    end

endmodule

`default_nettype wire

// ==== source/wisc_pkg.sv ====
/*
 * WISC core types
 * Width typedefs, opcode and forwarding enums, pipeline register structs
 */
`default_nettype none

`include "wisc_defs.svh"

package wisc_pkg;

    typedef logic [15:0] word_t;
    typedef logic [3:0]  reg_idx_t;
    // {Z, V, N}
    typedef logic [2:0]  flags_t;
    typedef logic [2:0]  cond_t;

    typedef enum logic [1:0] {
        FWD_NONE  = 2'd0,
        FWD_EXMEM = 2'd1,
        FWD_MEMWB = 2'd2
    } fwd_sel_t;

    typedef enum logic [3:0] {
        OP_ADD = `OP_ADD,
        OP_SUB = `OP_SUB,
        OP_XOR = `OP_XOR,
        OP_LW  = `OP_LW,
        OP_SW  = `OP_SW,
        OP_LLB = `OP_LLB,
        OP_HLB = `OP_HLB,
        OP_B   = `OP_B,
        OP_HLT = `OP_HLT
    } opcode_t;

    // ----------------------------------------
    // Pipeline registers
    // ----------------------------------------
    typedef struct packed {
        logic  valid;
        word_t instr;
        word_t pc_next;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        opcode_t  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        word_t    rs_data;
        word_t    rt_data;
        word_t    imm;
        word_t    pc_next;
        cond_t    cond;
        logic     write_reg;
        logic     mem_read;
        logic     mem_write;
        logic     sets_flags;
        logic     is_branch;
        logic     is_halt;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    result;
        word_t    store_data;
        logic     write_reg;
        logic     mem_read;
        logic     mem_write;
        logic     is_halt;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    result;
        logic     write_reg;
        logic     is_halt;
    } mem_wb_t;

endpackage

`default_nettype wire

// ==== source/wisc_defs.svh ====
/*
 * WISC core encodings and sizes
 * Opcode and branch-condition codes, flag bit positions, reset PC and data memory depth
 */
`ifndef WISC_DEFS_SVH
`define WISC_DEFS_SVH

// Opcodes, instr[15:12]
`define OP_ADD 4'h0
`define OP_SUB 4'h1
`define OP_XOR 4'h2
`define OP_LW  4'h8
`define OP_SW  4'h9
`define OP_LLB 4'hA
`define OP_HLB 4'hB
`define OP_B   4'hC
`define OP_HLT 4'hF

// Branch conditions, instr[11:9]
`define COND_NE 3'b000
`define COND_EQ 3'b001
`define COND_GT 3'b010
`define COND_LT 3'b011
`define COND_GE 3'b100
`define COND_LE 3'b101
`define COND_OV 3'b110
`define COND_UN 3'b111

// Flag register bit positions
`define FLAG_Z 2
`define FLAG_V 1
`define FLAG_N 0

`define RESET_PC   16'h0000
`define DMEM_WORDS 256

`endif
